//--- filelist.f
source/cpuPkg.sv
source/coreCtrlIf.sv
source/memBusIf.sv
source/programMemory.sv
source/alu.sv
source/registerFile.sv
source/datapath.sv
source/controlUnit.sv
source/writeTracer.sv
source/cpuTop.sv
verification/cpuTb.sv

//--- source/alu.sv
// Combinational 8-bit ALU, all results modulo 256 and shifts fill with zero
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
    input wire aluOp_e op_i,
    input wire data_t  a_i,
    input wire data_t  b_i,
    output data_t      result_o
);

    always_comb begin
        case (op_i)
            notA:    result_o = ~a_i;
            andAB:   result_o = a_i & b_i;
            orAB:    result_o = a_i | b_i;
            addAB:   result_o = a_i + b_i;    // Carry out dropped
            subAB:   result_o = a_i - b_i;    // Borrow wraps
            shlA:    result_o = {a_i[6:0], 1'b0};
            shrA:    result_o = {1'b0, a_i[7:1]};
            default: result_o = a_i;    // passA
        endcase
    end

endmodule

`default_nettype wire

//--- source/controlUnit.sv
// Run state, phase counter and opcode decode that sequence each 4-cycle instruction
`timescale 1ns/1ps
`default_nettype none

module controlUnit import cpuPkg::*; (
    input wire      CLK,
    input wire      reset_i,
    input wire      loadValid_i,
    input wire      start_i,
    output logic    loadEn_o,
    output logic    running_o,
    coreCtrlIf.ctrl ctrl
);

    logic       running;
    logic [1:0] phase;
    logic       execute;
    opcode_e    opcode;

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            running <= 1'b0;
            phase   <= 2'd0;
        end else if (!running) begin
            if (start_i) begin
                running <= 1'b1;    // First fetch in the next cycle
                phase   <= 2'd0;
            end
        end else begin
            phase <= phase + 2'd1;    // Wraps 3 -> 0
        end
    end

    assign running_o = running;
    assign loadEn_o  = loadValid_i & ~running;    // Loader locked out during a run

    assign ctrl.fetchHi = running & (phase == 2'd0);
    assign ctrl.fetchLo = running & (phase == 2'd1);
    assign execute      = running & (phase == 2'd3);

    assign opcode = opcode_e'(ctrl.instr[15:12]);

    // Operand indexes settle in phase 2, write strobes fire only in phase 3
    always_comb begin
        ctrl.aluOp    = passA;
        ctrl.wrSrc    = srcAlu;
        ctrl.dstIdx   = ctrl.instr[9:8];    // Type 1 register and type 2 destination share bits
        ctrl.srcAIdx  = ctrl.instr[5:4];    // Source 1 code, low two bits
        ctrl.srcBIdx  = ctrl.instr[1:0];    // Source 2 code, low two bits
        ctrl.regWrite = 1'b0;
        ctrl.pcLoad   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.flagLoad = 1'b0;

        case (opcode)
            opBra: begin
                ctrl.pcLoad = execute;
            end
            opBne: begin
                ctrl.pcLoad = execute & ~ctrl.zero;
            end
            opLd: begin
                ctrl.regWrite = execute;
                ctrl.wrSrc    = ctrl.instr[10] ? srcImm : srcMem;
            end
            opSt: begin
                ctrl.srcBIdx  = ctrl.instr[9:8];    // Store data from port B
                ctrl.memWrite = execute;
            end
            opMov, opNot, opAnd, opOr, opAdd, opSub, opLsl, opLsr: begin
                ctrl.regWrite = execute;
                ctrl.flagLoad = execute;
                case (opcode)
                    opNot:   ctrl.aluOp = notA;
                    opAnd:   ctrl.aluOp = andAB;
                    opOr:    ctrl.aluOp = orAB;
                    opAdd:   ctrl.aluOp = addAB;
                    opSub:   ctrl.aluOp = subAB;
                    opLsl:   ctrl.aluOp = shlA;
                    opLsr:   ctrl.aluOp = shrA;
                    default: ctrl.aluOp = passA;    // MOV
                endcase
            end
            opInc: begin
                ctrl.regWrite = execute;
                ctrl.flagLoad = execute;
                ctrl.wrSrc    = srcInc;
            end
            opDec: begin
                ctrl.regWrite = execute;
                ctrl.flagLoad = execute;
                ctrl.wrSrc    = srcDec;
            end
            default: begin
                // PUL and PSH do nothing
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/coreCtrlIf.sv
// Control strobes from the control unit to the datapath, with the IR and zero flag returned
`timescale 1ns/1ps
`default_nettype none

interface coreCtrlIf import cpuPkg::*; ();

    logic    fetchHi;     // Load IR high byte, PC+1
    logic    fetchLo;     // Load IR low byte, PC+1
    aluOp_e  aluOp;
    logic    regWrite;
    wrSrc_e  wrSrc;
    regIdx_t dstIdx;
    regIdx_t srcAIdx;
    regIdx_t srcBIdx;
    logic    pcLoad;      // Branch taken
    logic    memWrite;
    logic    flagLoad;    // Update zero from write data
    instr_t  instr;
    logic    zero;

    modport ctrl (
        output fetchHi, fetchLo, aluOp, regWrite, wrSrc, dstIdx, srcAIdx, srcBIdx,
        output pcLoad, memWrite, flagLoad,
        input  instr, zero
    );

    modport dp (
        input  fetchHi, fetchLo, aluOp, regWrite, wrSrc, dstIdx, srcAIdx, srcBIdx,
        input  pcLoad, memWrite, flagLoad,
        output instr, zero
    );

endinterface

`default_nettype wire

//--- source/cpuPkg.sv
// Shared widths, instruction fields and encodings for the CPU; RTL files import it with cpuPkg::*
`default_nettype none

package cpuPkg;

    localparam int DATA_W  = 8;
    localparam int INSTR_W = 16;
    localparam int ADDR_W  = 8;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [1:0]         regIdx_t;    // R1..R4 as 0..3, codes 4..7 in the instruction

    typedef enum logic [3:0] {
        opBra = 4'd0,
        opLd  = 4'd1,
        opSt  = 4'd2,
        opMov = 4'd3,
        opAnd = 4'd4,
        opOr  = 4'd5,
        opNot = 4'd6,
        opAdd = 4'd7,
        opSub = 4'd8,
        opLsl = 4'd9,
        opLsr = 4'd10,
        opPul = 4'd11,    // No-op
        opPsh = 4'd12,    // No-op
        opInc = 4'd13,
        opDec = 4'd14,
        opBne = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        passA,
        notA,
        andAB,
        orAB,
        addAB,
        subAB,
        shlA,
        shrA
    } aluOp_e;

    // Register write data select
    typedef enum logic [2:0] {
        srcAlu,
        srcImm,    // Instruction low byte
        srcMem,    // Memory at instruction low byte
        srcInc,
        srcDec
    } wrSrc_e;

    typedef enum logic {
        traceReg,
        traceMem
    } traceKind_e;

endpackage

`default_nettype wire

//--- source/cpuTop.sv
// Top level of the teaching CPU with loader and start inputs and the write trace output
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; (
    input wire         CLK,
    input wire         reset_i,
    input wire         loadValid_i,
    input wire addr_t  loadAddr_i,
    input wire data_t  loadData_i,
    input wire         start_i,
    output logic       running_o,
    output logic       traceValid_o,
    output traceKind_e traceKind_o,
    output addr_t      traceIndex_o,
    output data_t      traceData_o
);

    coreCtrlIf ctrlBus ();
    memBusIf   memBus ();

    logic    loadEn;
    logic    rfWrite;
    regIdx_t rfIdx;
    data_t   rfData;
    logic    memWrite;
    addr_t   memAddr;
    data_t   memData;

    programMemory progMem (
        .CLK        (CLK),
        .loadEn_i   (loadEn),
        .loadAddr_i (loadAddr_i),
        .loadData_i (loadData_i),
        .bus        (memBus.mem)
    );

    controlUnit ctrlUnit (
        .CLK         (CLK),
        .reset_i     (reset_i),
        .loadValid_i (loadValid_i),
        .start_i     (start_i),
        .loadEn_o    (loadEn),
        .running_o   (running_o),
        .ctrl        (ctrlBus.ctrl)
    );

    datapath dpath (
        .CLK        (CLK),
        .reset_i    (reset_i),
        .ctrl       (ctrlBus.dp),
        .bus        (memBus.master),
        .rfWrite_o  (rfWrite),
        .rfIdx_o    (rfIdx),
        .rfData_o   (rfData),
        .memWrite_o (memWrite),
        .memAddr_o  (memAddr),
        .memData_o  (memData)
    );

    writeTracer tracer (
        .CLK          (CLK),
        .reset_i      (reset_i),
        .rfWrite_i    (rfWrite),
        .rfIdx_i      (rfIdx),
        .rfData_i     (rfData),
        .memWrite_i   (memWrite),
        .memAddr_i    (memAddr),
        .memData_i    (memData),
        .traceValid_o (traceValid_o),
        .traceKind_o  (traceKind_o),
        .traceIndex_o (traceIndex_o),
        .traceData_o  (traceData_o)
    );

endmodule

`default_nettype wire

//--- source/datapath.sv
// PC, IR, register write mux, zero flag and memory addressing for the core
`timescale 1ns/1ps
`default_nettype none

module datapath import cpuPkg::*; (
    input wire        CLK,
    input wire        reset_i,
    coreCtrlIf.dp     ctrl,
    memBusIf.master   bus,
    output logic      rfWrite_o,
    output regIdx_t   rfIdx_o,
    output data_t     rfData_o,
    output logic      memWrite_o,
    output addr_t     memAddr_o,
    output data_t     memData_o
);

    addr_t  pc;
    instr_t ir;
    logic   zeroFlag;
    logic   fetch;
    data_t  rdA;
    data_t  rdB;
    data_t  aluResult;
    data_t  wrData;

    assign fetch = ctrl.fetchHi | ctrl.fetchLo;

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            pc       <= '0;
            ir       <= '0;
            zeroFlag <= 1'b0;
        end else begin
            if (ctrl.pcLoad) begin
                pc <= ir[7:0];    // Branch target is the low byte
            end else if (fetch) begin
                pc <= pc + 8'd1;
            end
            if (ctrl.fetchHi) begin
                ir[15:8] <= bus.rdData;
            end
            if (ctrl.fetchLo) begin
                ir[7:0] <= bus.rdData;
            end
            if (ctrl.flagLoad) begin
                zeroFlag <= (wrData == '0);
            end
        end
    end

    always_comb begin
        case (ctrl.wrSrc)
            srcImm:  wrData = ir[7:0];
            srcMem:  wrData = bus.rdData;
            srcInc:  wrData = rdA + 8'd1;
            srcDec:  wrData = rdA - 8'd1;
            default: wrData = aluResult;
        endcase
    end

    registerFile regFile (
        .CLK      (CLK),
        .reset_i  (reset_i),
        .wrEn_i   (ctrl.regWrite),
        .wrIdx_i  (ctrl.dstIdx),
        .wrData_i (wrData),
        .rdAIdx_i (ctrl.srcAIdx),
        .rdBIdx_i (ctrl.srcBIdx),
        .rdA_o    (rdA),
        .rdB_o    (rdB)
    );

    alu aluUnit (
        .op_i     (ctrl.aluOp),
        .a_i      (rdA),
        .b_i      (rdB),
        .result_o (aluResult)
    );

    assign ctrl.instr = ir;
    assign ctrl.zero  = zeroFlag;

    assign bus.addr   = fetch ? pc : ir[7:0];    // Operand address outside fetch
    assign bus.wrData = rdB;
    assign bus.wrEn   = ctrl.memWrite;

    assign rfWrite_o  = ctrl.regWrite;
    assign rfIdx_o    = ctrl.dstIdx;
    assign rfData_o   = wrData;
    assign memWrite_o = ctrl.memWrite;
    assign memAddr_o  = ir[7:0];
    assign memData_o  = rdB;

endmodule

`default_nettype wire

//--- source/memBusIf.sv
// Core side bus between the datapath and program memory, read is combinational on addr
`timescale 1ns/1ps
`default_nettype none

interface memBusIf import cpuPkg::*; ();

    addr_t addr;
    data_t wrData;
    logic  wrEn;
    data_t rdData;

    modport master (
        output addr, wrData, wrEn,
        input  rdData
    );

    modport mem (
        input  addr, wrData, wrEn,
        output rdData
    );

endinterface

`default_nettype wire

//--- source/programMemory.sv
// 256-byte program and data memory, written by the loader while idle or by stores while running
`timescale 1ns/1ps
`default_nettype none

module programMemory import cpuPkg::*; (
    input wire        CLK,
    input wire        loadEn_i,
    input wire addr_t loadAddr_i,
    input wire data_t loadData_i,
    memBusIf.mem      bus
);

    data_t memArray [2**ADDR_W];

    // Loader has priority; loadEn_i is only high while the core is idle
    always_ff @(posedge CLK) begin
        if (loadEn_i) begin
            memArray[loadAddr_i] <= loadData_i;
        end else if (bus.wrEn) begin
            memArray[bus.addr] <= bus.wrData;    // ST at phase 3 edge
        end
    end

    assign bus.rdData = memArray[bus.addr];    // Asynchronous read

endmodule

`default_nettype wire

//--- source/registerFile.sv
// Four general registers R1..R4 with one write port and two combinational read ports
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; (
    input wire          CLK,
    input wire          reset_i,
    input wire          wrEn_i,
    input wire regIdx_t wrIdx_i,
    input wire data_t   wrData_i,    // Load, increment or decrement value
    input wire regIdx_t rdAIdx_i,
    input wire regIdx_t rdBIdx_i,
    output data_t       rdA_o,
    output data_t       rdB_o
);

    data_t regs [4];

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i) begin
            regs[wrIdx_i] <= wrData_i;
        end
    end

    assign rdA_o = regs[rdAIdx_i];
    assign rdB_o = regs[rdBIdx_i];

endmodule

`default_nettype wire

//--- source/writeTracer.sv
// Registers each register or memory write into a one-cycle trace strobe
`timescale 1ns/1ps
`default_nettype none

module writeTracer import cpuPkg::*; (
    input wire          CLK,
    input wire          reset_i,
    input wire          rfWrite_i,
    input wire regIdx_t rfIdx_i,
    input wire data_t   rfData_i,
    input wire          memWrite_i,
    input wire addr_t   memAddr_i,
    input wire data_t   memData_i,
    output logic        traceValid_o,
    output traceKind_e  traceKind_o,
    output addr_t       traceIndex_o,
    output data_t       traceData_o
);

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            traceValid_o <= 1'b0;
            traceKind_o  <= traceReg;
        end else begin
            traceValid_o <= rfWrite_i | memWrite_i;
            traceKind_o  <= memWrite_i ? traceMem : traceReg;
        end
    end

    // Payload only, qualified by traceValid_o
    always_ff @(posedge CLK) begin
        if (memWrite_i) begin
            traceIndex_o <= memAddr_i;
            traceData_o  <= memData_i;
        end else begin
            traceIndex_o <= {6'd0, rfIdx_i};    // Register 0..3
            traceData_o  <= rfData_i;
        end
    end

endmodule

`default_nettype wire

//--- verification/cpuPatterns.txt
// Each test opens with byte count, instruction count, entry count and loader flag in hex
// followed by the program bytes and one kind index data triple per expected trace entry
06
// Immediate loads into R1 to R4
0A 04 04 00
14 5A 15 A5 16 00 17 FF 00 08
00 00 5A  00 01 A5  00 02 00  00 03 FF
// ALU operations with add overflow and subtract underflow
16 0A 0A 00
14 C8 15 5A 36 44 67 44 46 45 56 45 76 45 86 54 96 44 A6 44 00 14
00 00 C8  00 01 5A  00 02 C8  00 03 37  00 02 48
00 02 DA  00 02 22  00 02 92  00 02 90  00 02 64
// INC and DEC wrap around while PUL and PSH do nothing
0C 05 03 00
14 FF D4 44 B0 00 C0 00 E5 55 00 0A
00 00 FF  00 00 00  00 01 FF
// Store R3 to address 80 and load it back into R4
08 03 03 00
16 3C 22 80 13 80 00 06
00 02 3C  01 80 3C  00 03 3C
// Countdown loop from 3 with DEC and BNE
08 07 04 00
14 03 E4 44 F0 02 00 06
00 00 03  00 00 02  00 00 01  00 00 00
// Loader strobes during the run are ignored
0A 04 04 01
14 11 15 22 77 45 21 90 00 08
00 00 11  00 01 22  00 03 33  01 90 22

//--- verification/cpuTb.sv
// Self-checking testbench for cpuTop that runs each program of the pattern file and checks its trace
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam string PATTERN_FILE = "verification/cpuPatterns.txt";
    localparam int    CLK_HALF     = 2;    // 4 ns period

    logic       CLK;
    logic       reset_i;
    logic       loadValid_i;
    addr_t      loadAddr_i;
    data_t      loadData_i;
    logic       start_i;
    logic       running_o;
    logic       traceValid_o;
    traceKind_e traceKind_o;
    addr_t      traceIndex_o;
    data_t      traceData_o;

    logic [7:0] patterns [256];    // Whole pattern file, one byte per word
    int         patPtr;
    int         testErrors;
    int         passCount;
    int         failCount;

    cpuTop dut_i (
        .CLK          (CLK),
        .reset_i      (reset_i),
        .loadValid_i  (loadValid_i),
        .loadAddr_i   (loadAddr_i),
        .loadData_i   (loadData_i),
        .start_i      (start_i),
        .running_o    (running_o),
        .traceValid_o (traceValid_o),
        .traceKind_o  (traceKind_o),
        .traceIndex_o (traceIndex_o),
        .traceData_o  (traceData_o)
    );

    always #CLK_HALF CLK = ~CLK;

    function automatic int nextPattern();
        int value;
        value  = patterns[patPtr];
        patPtr = patPtr + 1;
        return value;
    endfunction

    task automatic compareKind(input string name, input traceKind_e expected,
                               input traceKind_e actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %s, got %s", $time, name,
                     expected.name(), actual.name());
            testErrors++;
        end
    endtask

    task automatic checkAddress(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic verifyData(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic inspectFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic resetDut();
        @(posedge CLK);
        reset_i <= 1'b1;
        repeat (2) @(posedge CLK);
        reset_i <= 1'b0;
    endtask

    task automatic runTest(input int testNum);
        int         byteCount;
        int         instrCount;
        int         entryCount;
        int         loadWhileRun;
        int         limit;
        int         seen;
        data_t      progBytes [$];
        traceKind_e expKind [$];
        addr_t      expIndex [$];
        data_t      expData [$];

        testErrors   = 0;
        byteCount    = nextPattern();
        instrCount   = nextPattern();
        entryCount   = nextPattern();
        loadWhileRun = nextPattern();
        for (int i = 0; i < byteCount; i++) begin
            progBytes.push_back(data_t'(nextPattern()));
        end
        for (int i = 0; i < entryCount; i++) begin
            expKind.push_back(traceKind_e'(1'(nextPattern())));
            expIndex.push_back(addr_t'(nextPattern()));
            expData.push_back(data_t'(nextPattern()));
        end

        resetDut();
        @(negedge CLK);    // Idle state right after reset
        inspectFlag("running_o", 1'b0, running_o);
        inspectFlag("traceValid_o", 1'b0, traceValid_o);
        for (int i = 0; i < byteCount; i++) begin
            @(posedge CLK);
            loadValid_i <= 1'b1;
            loadAddr_i  <= addr_t'(i);
            loadData_i  <= progBytes[i];
        end
        @(posedge CLK);
        loadValid_i <= 1'b0;
        start_i     <= 1'b1;

        limit = 4 * instrCount + 20;    // Four cycles per instruction plus margin
        seen  = 0;
        for (int cycle = 0; cycle < limit; cycle++) begin
            @(posedge CLK);
            start_i     <= 1'b0;
            loadValid_i <= (loadWhileRun != 0);    // Try to overwrite the running program
            loadAddr_i  <= addr_t'(cycle % byteCount);
            loadData_i  <= ~progBytes[cycle % byteCount];
            @(negedge CLK);    // Trace outputs are settled here
            inspectFlag("running_o", 1'b1, running_o);
            if (traceValid_o) begin
                if (seen < entryCount) begin
                    compareKind("traceKind_o", expKind[seen], traceKind_o);
                    checkAddress("traceIndex_o", expIndex[seen], traceIndex_o);
                    verifyData("traceData_o", expData[seen], traceData_o);
                end else begin
                    $display("Test %0d: trace entry beyond the %0d expected ones at %0t ns",
                             testNum, entryCount, $time);
                    testErrors++;
                end
                seen++;
            end
        end
        @(posedge CLK);
        loadValid_i <= 1'b0;

        if (seen < entryCount) begin
            $display("Test %0d: only %0d of %0d trace entries seen within %0d cycles",
                     testNum, seen, entryCount, limit);
            testErrors++;
        end
        if (testErrors == 0) begin
            $display("Test %0d passed with %0d trace entries", testNum, seen);
            passCount++;
        end else begin
            $display("Test %0d failed with %0d errors", testNum, testErrors);
            failCount++;
        end
    endtask

    initial begin
        int numTests;
        CLK         = 1'b0;
        reset_i     = 1'b1;
        loadValid_i = 1'b0;
        loadAddr_i  = '0;
        loadData_i  = '0;
        start_i     = 1'b0;
        patPtr      = 1;    // Word 0 holds the test count
        passCount   = 0;
        failCount   = 0;
        $readmemh(PATTERN_FILE, patterns);
        if ($isunknown(patterns[0]) || patterns[0] == 8'd0) begin
            $display("Pattern file %s could not be read or holds no tests", PATTERN_FILE);
            failCount = 1;
            numTests  = 0;
        end else begin
            numTests = patterns[0];
        end
        for (int t = 1; t <= numTests; t++) begin
            runTest(t);
        end
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
